/* hdl/rv_pipe_defs.svh */
`ifndef RV_PIPE_DEFS_SVH
`define RV_PIPE_DEFS_SVH

// Datapath width
`define XLEN            32

// Register file geometry
`define REG_ADDR_W      5
`define REG_COUNT       32

// RV32I opcodes of the two supported ALU groups
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011

`endif

/* hdl/rv_pipe_pkg.sv */
`default_nettype none

`include "rv_pipe_defs.svh"

package rv_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Wishbone classic request, write path only
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`XLEN-1:0]       dat;
    } wb_req_s;

    // Instruction word laid out in R/I field order
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } instr_s;

    typedef struct packed {
        alu_op_e                alu_op;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       rs1_val;
        logic [`XLEN-1:0]       rs2_val;
        logic [`XLEN-1:0]       imm;
        logic                   use_imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   writes_rd;
        logic                   illegal;
    } id2ex_s;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        logic                   writes_rd;
        logic                   illegal;
    } ex2res_s;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } rf_wr_s;

    // Retired instruction as seen on the output port
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        logic                   illegal;
    } result_s;

endpackage : rv_pipe_pkg

`default_nettype wire

/* hdl/pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       stall_i,
    input  wire logic       valid_i,
    input  wire payload_t   data_i,
    output logic            valid_o,
    output payload_t        data_o
);

    // Valid bit is the only control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            data_o <= data_i;
        end
    end

    // A stall freezes the stage contents for the next cycle
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_i |=> $stable(data_o) && $stable(valid_o)
    ) else $error("pipe_stage: contents changed during stall");

endmodule : pipe_stage

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_defs.svh"

module decode_stage (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   valid_i,
    input  wire rv_pipe_pkg::instr_s    instr_i,
    input  wire rv_pipe_pkg::rf_wr_s    rf_wr_i,
    output rv_pipe_pkg::id2ex_s         op_o
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic [`XLEN-1:0]       regs [`REG_COUNT];
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    rv_pipe_pkg::alu_op_e   alu_op;
    logic                   use_imm;
    logic                   legal;

    // Register file, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wr_i.en) begin
            regs[rf_wr_i.addr] <= rf_wr_i.data;
        end
    end

    // x0 reads zero; a same-cycle retire write is bypassed
    assign rs1_val = (instr_i.rs1 == '0) ? '0 :
                     (rf_wr_i.en && rf_wr_i.addr == instr_i.rs1) ? rf_wr_i.data :
                     regs[instr_i.rs1];
    assign rs2_val = (instr_i.rs2 == '0) ? '0 :
                     (rf_wr_i.en && rf_wr_i.addr == instr_i.rs2) ? rf_wr_i.data :
                     regs[instr_i.rs2];

    always_comb begin
        alu_op  = rv_pipe_pkg::ALU_ADD;
        use_imm = 1'b0;
        legal   = 1'b1;
        if (instr_i.opcode == `OPC_OP) begin
            case ({instr_i.funct7, instr_i.funct3})
                {F7_BASE, 3'b000}: alu_op = rv_pipe_pkg::ALU_ADD;
                {F7_ALT,  3'b000}: alu_op = rv_pipe_pkg::ALU_SUB;
                {F7_BASE, 3'b001}: alu_op = rv_pipe_pkg::ALU_SLL;
                {F7_BASE, 3'b010}: alu_op = rv_pipe_pkg::ALU_SLT;
                {F7_BASE, 3'b011}: alu_op = rv_pipe_pkg::ALU_SLTU;
                {F7_BASE, 3'b100}: alu_op = rv_pipe_pkg::ALU_XOR;
                {F7_BASE, 3'b101}: alu_op = rv_pipe_pkg::ALU_SRL;
                {F7_ALT,  3'b101}: alu_op = rv_pipe_pkg::ALU_SRA;
                {F7_BASE, 3'b110}: alu_op = rv_pipe_pkg::ALU_OR;
                {F7_BASE, 3'b111}: alu_op = rv_pipe_pkg::ALU_AND;
                default:           legal  = 1'b0;
            endcase
        end else if (instr_i.opcode == `OPC_OP_IMM) begin
            use_imm = 1'b1;
            case (instr_i.funct3)
                3'b000: alu_op = rv_pipe_pkg::ALU_ADD;
                3'b010: alu_op = rv_pipe_pkg::ALU_SLT;
                3'b011: alu_op = rv_pipe_pkg::ALU_SLTU;
                3'b100: alu_op = rv_pipe_pkg::ALU_XOR;
                3'b110: alu_op = rv_pipe_pkg::ALU_OR;
                3'b111: alu_op = rv_pipe_pkg::ALU_AND;
                // Immediate shifts still check funct7
                3'b001: begin
                    alu_op = rv_pipe_pkg::ALU_SLL;
                    legal  = (instr_i.funct7 == F7_BASE);
                end
                3'b101: begin
                    alu_op = (instr_i.funct7 == F7_ALT) ? rv_pipe_pkg::ALU_SRA
                                                        : rv_pipe_pkg::ALU_SRL;
                    legal  = (instr_i.funct7 == F7_BASE) || (instr_i.funct7 == F7_ALT);
                end
            endcase
        end else begin
            legal = 1'b0;
        end
    end

    always_comb begin
        op_o.alu_op    = alu_op;
        op_o.rs1       = instr_i.rs1;
        op_o.rs2       = instr_i.rs2;
        op_o.rs1_val   = rs1_val;
        op_o.rs2_val   = rs2_val;
        // I-type immediate, sign extended
        op_o.imm       = {{(`XLEN-12){instr_i.funct7[6]}}, instr_i.funct7, instr_i.rs2};
        op_o.use_imm   = use_imm;
        op_o.rd        = instr_i.rd;
        op_o.writes_rd = valid_i & legal;
        op_o.illegal   = valid_i & ~legal;
    end

    // Retire logic in the result stage must never target x0
    a_no_x0_write : assert property (
        @(posedge clk) disable iff (!rst_n)
        rf_wr_i.en |-> (rf_wr_i.addr != '0)
    ) else $error("decode_stage: register write to x0 enabled");

endmodule : decode_stage

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_defs.svh"

module execute_stage (
    input  wire rv_pipe_pkg::id2ex_s    op_i,
    input  wire logic                   fwd_valid_i,
    input  wire rv_pipe_pkg::ex2res_s   fwd_i,
    output rv_pipe_pkg::ex2res_s        res_o
);

    logic                   fwd_a;
    logic                   fwd_b;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       rs2_val;
    logic [`XLEN-1:0]       op_b;
    logic [4:0]             shamt;
    logic [`XLEN-1:0]       alu_res;

    // Result register holds the instruction one ahead of this one
    assign fwd_a = fwd_valid_i && fwd_i.writes_rd && (op_i.rs1 != '0)
                   && (fwd_i.rd == op_i.rs1);
    assign fwd_b = fwd_valid_i && fwd_i.writes_rd && (op_i.rs2 != '0)
                   && (fwd_i.rd == op_i.rs2);

    assign op_a    = fwd_a ? fwd_i.data : op_i.rs1_val;
    assign rs2_val = fwd_b ? fwd_i.data : op_i.rs2_val;
    assign op_b    = op_i.use_imm ? op_i.imm : rs2_val;
    assign shamt   = op_b[4:0];

    always_comb begin
        case (op_i.alu_op)
            rv_pipe_pkg::ALU_ADD:  alu_res = op_a + op_b;
            rv_pipe_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rv_pipe_pkg::ALU_SLL:  alu_res = op_a << shamt;
            rv_pipe_pkg::ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pipe_pkg::ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, op_a < op_b};
            rv_pipe_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv_pipe_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            rv_pipe_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            rv_pipe_pkg::ALU_OR:   alu_res = op_a | op_b;
            rv_pipe_pkg::ALU_AND:  alu_res = op_a & op_b;
            default:               alu_res = '0;
        endcase
    end

    always_comb begin
        res_o.rd        = op_i.rd;
        // Illegal instructions carry zero data
        res_o.data      = op_i.illegal ? '0 : alu_res;
        res_o.writes_rd = op_i.writes_rd;
        res_o.illegal   = op_i.illegal;
    end

endmodule : execute_stage

`default_nettype wire

/* hdl/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   valid_i,
    input  wire rv_pipe_pkg::ex2res_s   res_i,
    input  wire logic                   ready_i,
    output logic                        stall_o,
    output rv_pipe_pkg::ex2res_s        res_o,
    output rv_pipe_pkg::result_s        result_o,
    output logic                        result_valid_o,
    output rv_pipe_pkg::rf_wr_s         rf_wr_o
);

    rv_pipe_pkg::ex2res_s   res_q;
    logic                   valid_q;
    logic                   retire;

    assign retire  = valid_q & ready_i;
    // Unaccepted result freezes the whole pipe
    assign stall_o = valid_q & ~ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            res_q <= res_i;
        end
    end

    assign res_o          = res_q;
    assign result_valid_o = valid_q;

    always_comb begin
        result_o.rd      = res_q.writes_rd ? res_q.rd : '0;
        result_o.data    = res_q.data;
        result_o.illegal = res_q.illegal;
    end

    // Register write lands on the retire edge
    always_comb begin
        rf_wr_o.en   = retire & res_q.writes_rd & (res_q.rd != '0);
        rf_wr_o.addr = res_q.rd;
        rf_wr_o.data = res_q.data;
    end

    a_result_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid_o && !ready_i |=> result_valid_o && $stable(result_o)
    ) else $error("result_stage: result changed while waiting for ready");

endmodule : result_stage

`default_nettype wire

/* hdl/core_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_pipe_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire rv_pipe_pkg::wb_req_s   wb_req_i,
    output logic                        wb_ack_o,
    input  wire logic                   result_ready_i,
    output rv_pipe_pkg::result_s        result_o,
    output logic                        result_valid_o
);

    rv_pipe_pkg::instr_s    instr_q;
    logic                   instr_valid;
    rv_pipe_pkg::id2ex_s    id_op;
    rv_pipe_pkg::id2ex_s    ex_op;
    logic                   ex_valid;
    rv_pipe_pkg::ex2res_s   ex_res;
    rv_pipe_pkg::ex2res_s   res_fb;
    rv_pipe_pkg::rf_wr_s    rf_wr;
    logic                   stall;

    // Write-only slave; ack doubles as the accept strobe
    assign wb_ack_o = wb_req_i.cyc & wb_req_i.stb & wb_req_i.we & ~stall;

    pipe_stage #(
        .payload_t  (rv_pipe_pkg::instr_s)
    ) instr_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_i    (stall),
        .valid_i    (wb_ack_o),
        .data_i     (rv_pipe_pkg::instr_s'(wb_req_i.dat)),
        .valid_o    (instr_valid),
        .data_o     (instr_q)
    );

    decode_stage decode_module (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (instr_valid),
        .instr_i    (instr_q),
        .rf_wr_i    (rf_wr),
        .op_o       (id_op)
    );

    pipe_stage #(
        .payload_t  (rv_pipe_pkg::id2ex_s)
    ) id2ex_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_i    (stall),
        .valid_i    (instr_valid),
        .data_i     (id_op),
        .valid_o    (ex_valid),
        .data_o     (ex_op)
    );

    execute_stage execute_module (
        .op_i           (ex_op),
        .fwd_valid_i    (result_valid_o),
        .fwd_i          (res_fb),
        .res_o          (ex_res)
    );

    result_stage result_module (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (ex_valid),
        .res_i          (ex_res),
        .ready_i        (result_ready_i),
        .stall_o        (stall),
        .res_o          (res_fb),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .rf_wr_o        (rf_wr)
    );

endmodule : core_pipe_top

`default_nettype wire

/* testbench/tb_core_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_pipe_defs.svh"

module tb_core_pipe;

    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = 8 * NUM_INSTR + 100;

    logic                   clk;
    logic                   rst_n;
    rv_pipe_pkg::wb_req_s   wb_req;
    logic                   wb_ack;
    logic                   result_ready;
    rv_pipe_pkg::result_s   result;
    logic                   result_valid;

    integer                 seed;
    int                     cycle_count = 0;
    logic [`XLEN-1:0]       model_regs [`REG_COUNT];
    rv_pipe_pkg::result_s   exp_queue [$];
    // Occupancy of instr, id2ex and result registers, bit 2 is the result stage
    logic [2:0]             occ;
    logic                   hold_pending;
    rv_pipe_pkg::result_s   held_result;

    core_pipe_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_req_i       (wb_req),
        .wb_ack_o       (wb_ack),
        .result_ready_i (result_ready),
        .result_o       (result),
        .result_valid_o (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic verify_result(input string name, input rv_pipe_pkg::result_s got,
                                 input rv_pipe_pkg::result_s exp);
        if (got !== exp) begin
            $display("Error: %s expected rd=%h data=%h ill=%h got rd=%h data=%h ill=%h",
                     name, exp.rd, exp.data, exp.illegal, got.rd, got.data, got.illegal);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            abort_run();
        end
    endtask

    // Reference model of the RV32I ALU groups, runs in program order at accept
    task automatic model_accept(input logic [31:0] word);
        logic [6:0]             opc;
        logic [4:0]             rd;
        logic [2:0]             f3;
        logic [6:0]             f7;
        logic                   is_imm;
        logic                   legal;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            res;
        rv_pipe_pkg::result_s   expected;
        opc    = word[6:0];
        rd     = word[11:7];
        f3     = word[14:12];
        f7     = word[31:25];
        is_imm = (opc == `OPC_OP_IMM);
        a      = model_regs[word[19:15]];
        b      = is_imm ? {{20{word[31]}}, word[31:20]} : model_regs[word[24:20]];
        if (opc == `OPC_OP) begin
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end else if (is_imm) begin
            legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                    (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        end else begin
            legal = 1'b0;
        end
        case (f3)
            3'd0: res = (!is_imm && f7 == 7'h20) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (f7 == 7'h20) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (legal && rd != 5'd0) model_regs[rd] = res;
        expected.rd      = legal ? rd : 5'd0;
        expected.data    = legal ? res : 32'd0;
        expected.illegal = ~legal;
        exp_queue.push_back(expected);
    endtask

    // Registers limited to x0..x3 so that dependences stay dense
    task automatic random_instr(output logic [31:0] word);
        logic [31:0] r;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r   = $random(seed);
        f3  = r[6:4];
        rd  = {3'b000, r[8:7]};
        rs1 = {3'b000, r[10:9]};
        rs2 = {3'b000, r[12:11]};
        f7  = (r[25] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        // Odd funct7 gives an illegal encoding on a legal opcode
        if (r[28:26] == 3'b111) f7 = {r[31:26], 1'b1};
        if (r[3:0] == 4'd0) begin
            word = $random(seed);
        end else if (r[3]) begin
            word = {f7, rs2, rs1, f3, rd, `OPC_OP};
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            word = {f7, r[17:13], rs1, f3, rd, `OPC_OP_IMM};
        end else begin
            word = {r[24:13], rs1, f3, rd, `OPC_OP_IMM};
        end
    endtask

    // One clock cycle: drive at the falling edge, check what the next rising edge sees
    task automatic drive_cycle(input logic cyc, input logic stb, input logic we,
                               input logic [31:0] word, input logic ready,
                               output logic accepted);
        logic                   exp_ack;
        logic                   stall_m;
        rv_pipe_pkg::result_s   expected;
        @(negedge clk);
        wb_req.cyc   = cyc;
        wb_req.stb   = stb;
        wb_req.we    = we;
        wb_req.dat   = word;
        result_ready = ready;
        #1;
        stall_m = occ[2] & ~ready;
        exp_ack = cyc & stb & we & ~stall_m;
        compare_flag("result_valid_o", result_valid, occ[2]);
        compare_flag("wb_ack_o", wb_ack, exp_ack);
        if (hold_pending) verify_result("result_o", result, held_result);
        if (occ[2] && ready) begin
            if (exp_queue.size() == 0) begin
                $display("Result retired with no instruction in flight");
                abort_run();
            end
            expected = exp_queue.pop_front();
            verify_result("result_o", result, expected);
        end
        hold_pending = stall_m;
        held_result  = result;
        if (exp_ack) model_accept(word);
        if (!stall_m) occ = {occ[1:0], exp_ack};
        accepted = exp_ack;
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] r;
        logic        accepted;
        logic        pending;
        int          sent;
        seed         = 32'ha284;
        rst_n        = 1'b0;
        wb_req       = '0;
        result_ready = 1'b0;
        occ          = 3'b000;
        hold_pending = 1'b0;
        held_result  = '0;
        word         = 32'd0;
        pending      = 1'b0;
        sent         = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle after reset, no valid and no ack
        repeat (3) drive_cycle(1'b0, 1'b0, 1'b0, word, 1'b0, accepted);

        // Read strobe and a strobe outside a cycle get no ack
        drive_cycle(1'b1, 1'b1, 1'b0, word, 1'b0, accepted);
        drive_cycle(1'b0, 1'b1, 1'b1, word, 1'b0, accepted);

        // Single addi into an empty pipe; occupancy model pins the 3-edge latency
        word = {12'h123, 5'd0, 3'd0, 5'd1, `OPC_OP_IMM};
        drive_cycle(1'b1, 1'b1, 1'b1, word, 1'b1, accepted);
        repeat (4) drive_cycle(1'b1, 1'b0, 1'b1, word, 1'b1, accepted);

        // Random traffic with stb gaps and ready low about one cycle in four
        while (sent < NUM_INSTR) begin
            r = $random(seed);
            if (!pending && r[1:0] != 2'd0) begin
                random_instr(word);
                pending = 1'b1;
            end
            drive_cycle(1'b1, pending, 1'b1, word, (r[3:2] != 2'd0), accepted);
            if (accepted) begin
                pending = 1'b0;
                sent++;
            end
        end

        while (exp_queue.size() != 0) begin
            drive_cycle(1'b1, 1'b0, 1'b1, word, 1'b1, accepted);
        end
        repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, word, 1'b1, accepted);

        if (exp_queue.size() == 0 && occ == 3'b000) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("Pipe did not drain, %0d results outstanding", exp_queue.size());
            abort_run();
        end
    end

endmodule : tb_core_pipe

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/rv_pipe_pkg.sv
hdl/pipe_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/core_pipe_top.sv
testbench/tb_core_pipe.sv

/* Makefile */
SIM        := verilator
TOP        := tb_core_pipe
RTL_TOP    := core_pipe_top
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
